// ==== source/oam_pkg.sv ====
`default_nettype none

package oam_pkg;

	// ------------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------------

	localparam int oam_entries = 40;              // Sprite entries.
	localparam int oam_bytes   = 160;             // Four bytes per entry.
	localparam int oam_rows    = oam_bytes / 2;   // One row holds an even and an odd byte.
	localparam int dma_len     = 160;             // Bytes per DMA transfer.

	localparam logic [7:0] open_bus = 8'hFF;      // What a lost read returns.

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------

	typedef enum logic [1:0] {
		own_cpu,
		own_dma,
		own_scan,
		own_render
	} oam_owner_e;

	// Byte view, as the CPU and DMA see it.
	typedef struct packed {
		logic [6:0] row;
		logic       bank;   // 0 selects bank A, 1 selects bank B.
	} oam_byte_addr_t;

	// Entry view. Field 0 is Y, 1 is X, 2 is tile, 3 is attribute.
	typedef struct packed {
		logic [5:0] index;
		logic [1:0] field;
	} oam_entry_addr_t;

	typedef union packed {
		oam_byte_addr_t  byte_addr;
		oam_entry_addr_t entry;
	} oam_addr_u;

	typedef struct packed {
		logic [6:0] row;
		logic       cs_a;
		logic       cs_b;
		logic       we;
		logic [7:0] wdata;
		oam_owner_e owner;
	} oam_cmd_t;

	typedef struct packed {
		logic [7:0] hi;     // Bank B byte.
		logic [7:0] lo;     // Bank A byte.
	} oam_word_t;

	typedef struct packed {
		logic       valid;
		logic [5:0] index;
		logic [7:0] y;
		logic [7:0] x;
	} scan_entry_t;

endpackage

`default_nettype wire

// ==== source/oam_arbiter.sv ====
`default_nettype none

module oam_arbiter (
	input  wire                  clk,
	input  wire                  arst_n,

	input  wire                  cpu_rd,
	input  wire                  cpu_wr,
	input  wire oam_pkg::oam_addr_u cpu_addr,
	input  wire [7:0]            cpu_wdata,

	input  wire                  dma_req,
	input  wire oam_pkg::oam_addr_u dma_addr,
	input  wire [7:0]            dma_wdata,

	input  wire                  scan_req,
	input  wire oam_pkg::oam_addr_u scan_addr,

	input  wire                  render_req,
	input  wire [5:0]            render_index,

	input  wire oam_pkg::oam_word_t rd_word,

	output oam_pkg::oam_cmd_t    cmd,
	output logic [7:0]           cpu_rdata,
	output logic                 cpu_rvalid,
	output oam_pkg::oam_word_t   scan_word,
	output logic                 scan_word_valid,
	output logic [7:0]           render_tile,
	output logic [7:0]           render_attr,
	output logic                 render_valid
);
	import oam_pkg::*;

	oam_addr_u  render_addr;
	oam_owner_e owner_q;
	logic       cpu_rd_q;
	logic       cpu_sel_q;
	logic       scan_req_q;
	logic       render_req_q;

	// A write touches one bank, a read fetches the whole row.
	function automatic oam_cmd_t byte_cmd(
		input oam_addr_u  addr,
		input logic       wr,
		input logic [7:0] wdata,
		input oam_owner_e owner
	);
		oam_cmd_t c;
		c.row   = addr.byte_addr.row;
		c.cs_a  = !wr || !addr.byte_addr.bank;
		c.cs_b  = !wr || addr.byte_addr.bank;
		c.we    = wr;
		c.wdata = wdata;
		c.owner = owner;
		return c;
	endfunction

	always_comb begin
		render_addr.entry.index = render_index;
		render_addr.entry.field = 2'd2;   // Tile and attribute row.
	end

	// ------------------------------------------------------------------------
	// Fixed priority grant
	// ------------------------------------------------------------------------

	always_comb begin
		cmd       = '0;
		cmd.owner = own_cpu;
		if (dma_req)
			cmd = byte_cmd(dma_addr, 1'b1, dma_wdata, own_dma);
		else if (scan_req)
			cmd = byte_cmd(scan_addr, 1'b0, 8'h00, own_scan);
		else if (render_req)
			cmd = byte_cmd(render_addr, 1'b0, 8'h00, own_render);
		else if (cpu_wr || cpu_rd)
			cmd = byte_cmd(cpu_addr, cpu_wr, cpu_wdata, own_cpu);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owner_q      <= own_cpu;
			cpu_rd_q     <= 1'b0;
			scan_req_q   <= 1'b0;
			render_req_q <= 1'b0;
		end else begin
			owner_q      <= cmd.owner;
			cpu_rd_q     <= cpu_rd;
			scan_req_q   <= scan_req;
			render_req_q <= render_req;
		end
	end

	always_ff @(posedge clk)
		cpu_sel_q <= cpu_addr.byte_addr.bank;

	// ------------------------------------------------------------------------
	// Read return, FF when the request lost
	// ------------------------------------------------------------------------

	assign cpu_rvalid   = cpu_rd_q;
	assign cpu_rdata    = (owner_q != own_cpu) ? open_bus :
	                      cpu_sel_q ? rd_word.hi : rd_word.lo;

	assign scan_word_valid = scan_req_q;
	assign scan_word       = (owner_q == own_scan) ? rd_word : {open_bus, open_bus};

	assign render_valid = render_req_q;
	assign render_tile  = (owner_q == own_render) ? rd_word.lo : open_bus;
	assign render_attr  = (owner_q == own_render) ? rd_word.hi : open_bus;

endmodule

`default_nettype wire

// ==== source/oam_scan_counter.sv ====
`default_nettype none

module oam_scan_counter (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     scan_start,
	input  wire oam_pkg::oam_word_t scan_word,
	input  wire                     scan_word_valid,

	output logic                    scan_req,
	output oam_pkg::oam_addr_u      scan_addr,
	output logic                    scan_active,
	output oam_pkg::scan_entry_t    scan_entry,
	output logic                    scan_done
);
	import oam_pkg::*;

	localparam logic [5:0] last_index = 6'(oam_entries - 1);

	logic       active_q;
	logic [5:0] idx_q;
	logic [5:0] idx_d_q;    // Entry number of the word now returning.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active_q <= 1'b0;
			idx_q    <= '0;
		end else if (scan_start) begin
			active_q <= 1'b1;
			idx_q    <= '0;
		end else if (active_q) begin
			idx_q <= idx_q + 6'd1;
			if (idx_q == last_index)
				active_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			idx_d_q <= '0;
		else if (active_q)
			idx_d_q <= idx_q;
	end

	assign scan_req    = active_q;
	assign scan_active = active_q;

	always_comb begin
		scan_addr.entry.index = idx_q;
		scan_addr.entry.field = 2'd0;   // Y and X share one row.
	end

	always_comb begin
		scan_entry.valid = scan_word_valid;
		scan_entry.index = idx_d_q;
		scan_entry.y     = scan_word.lo;
		scan_entry.x     = scan_word.hi;
	end

	assign scan_done = scan_word_valid && (idx_d_q == last_index);

endmodule

`default_nettype wire

// ==== source/oam_dma_engine.sv ====
`default_nettype none

module oam_dma_engine (
	input  wire                clk,
	input  wire                arst_n,
	input  wire                dma_start,
	input  wire [7:0]          dma_page,
	input  wire [7:0]          dma_mem_data,

	output logic [15:0]        dma_mem_addr,
	output logic               dma_req,
	output oam_pkg::oam_addr_u dma_addr,
	output logic [7:0]         dma_wdata,
	output logic               dma_busy
);
	import oam_pkg::*;

	localparam logic [7:0] last_byte = 8'(dma_len - 1);

	logic       busy_q;
	logic [7:0] cnt_q;
	logic [7:0] page_q;

	// ------------------------------------------------------------------------
	// Transfer control
	// ------------------------------------------------------------------------

	// A start while busy begins again at byte 0.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (dma_start) begin
			busy_q <= 1'b1;
			cnt_q  <= '0;
		end else if (busy_q) begin
			cnt_q <= cnt_q + 8'd1;
			if (cnt_q == last_byte)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (dma_start)
			page_q <= dma_page;
	end

	assign dma_busy = busy_q;
	assign dma_req  = busy_q;

	// ------------------------------------------------------------------------
	// Source read and OAM write
	// ------------------------------------------------------------------------

	// External memory is combinational, the byte comes back this cycle.
	assign dma_mem_addr = {page_q, cnt_q};

	always_comb begin
		dma_addr.byte_addr.row  = cnt_q[7:1];
		dma_addr.byte_addr.bank = cnt_q[0];
	end

	assign dma_wdata = dma_mem_data;

endmodule

`default_nettype wire

// ==== source/oam_ram.sv ====
`default_nettype none

module oam_ram (
	input  wire                     clk,
	input  wire oam_pkg::oam_cmd_t  cmd,
	output oam_pkg::oam_word_t      rd_word
);
	import oam_pkg::*;

	logic [7:0] bank_a [oam_rows];   // Even bytes.
	logic [7:0] bank_b [oam_rows];   // Odd bytes.
	logic       row_ok;
	logic       rd_en;

	// Entry addresses can point past entry 39.
	assign row_ok = cmd.row < 7'(oam_rows);
	assign rd_en  = cmd.cs_a && cmd.cs_b && !cmd.we;

	// ------------------------------------------------------------------------
	// Byte writes
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (cmd.we && row_ok) begin
			if (cmd.cs_a)
				bank_a[cmd.row] <= cmd.wdata;
			if (cmd.cs_b)
				bank_b[cmd.row] <= cmd.wdata;
		end
	end

	// ------------------------------------------------------------------------
	// Row read
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rd_en) begin
			if (row_ok) begin
				rd_word.lo <= bank_a[cmd.row];
				rd_word.hi <= bank_b[cmd.row];
			end else begin
				rd_word.lo <= open_bus;
				rd_word.hi <= open_bus;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ppu_oam.sv ====
`default_nettype none

module ppu_oam (
	input  wire                     clk,
	input  wire                     arst_n,

	input  wire                     cpu_rd,
	input  wire                     cpu_wr,
	input  wire oam_pkg::oam_addr_u cpu_addr,
	input  wire [7:0]               cpu_wdata,
	output logic [7:0]              cpu_rdata,
	output logic                    cpu_rvalid,

	input  wire                     dma_start,
	input  wire [7:0]               dma_page,
	output logic [15:0]             dma_mem_addr,
	input  wire [7:0]               dma_mem_data,
	output logic                    dma_busy,

	input  wire                     scan_start,
	output logic                    scan_active,
	output oam_pkg::scan_entry_t    scan_entry,
	output logic                    scan_done,

	input  wire                     render_req,
	input  wire [5:0]               render_index,
	output logic [7:0]              render_tile,
	output logic [7:0]              render_attr,
	output logic                    render_valid
);
	import oam_pkg::*;

	oam_cmd_t  cmd;
	oam_word_t rd_word;
	oam_addr_u dma_addr;
	oam_addr_u scan_addr;
	oam_word_t scan_word;
	logic      dma_req;
	logic      scan_req;
	logic      scan_word_valid;
	logic [7:0] dma_wdata;

	oam_arbiter i_arbiter (
		.clk             (clk),
		.arst_n          (arst_n),
		.cpu_rd          (cpu_rd),
		.cpu_wr          (cpu_wr),
		.cpu_addr        (cpu_addr),
		.cpu_wdata       (cpu_wdata),
		.dma_req         (dma_req),
		.dma_addr        (dma_addr),
		.dma_wdata       (dma_wdata),
		.scan_req        (scan_req),
		.scan_addr       (scan_addr),
		.render_req      (render_req),
		.render_index    (render_index),
		.rd_word         (rd_word),
		.cmd             (cmd),
		.cpu_rdata       (cpu_rdata),
		.cpu_rvalid      (cpu_rvalid),
		.scan_word       (scan_word),
		.scan_word_valid (scan_word_valid),
		.render_tile     (render_tile),
		.render_attr     (render_attr),
		.render_valid    (render_valid)
	);

	oam_scan_counter i_scan (
		.clk             (clk),
		.arst_n          (arst_n),
		.scan_start      (scan_start),
		.scan_word       (scan_word),
		.scan_word_valid (scan_word_valid),
		.scan_req        (scan_req),
		.scan_addr       (scan_addr),
		.scan_active     (scan_active),
		.scan_entry      (scan_entry),
		.scan_done       (scan_done)
	);

	oam_dma_engine i_dma (
		.clk          (clk),
		.arst_n       (arst_n),
		.dma_start    (dma_start),
		.dma_page     (dma_page),
		.dma_mem_data (dma_mem_data),
		.dma_mem_addr (dma_mem_addr),
		.dma_req      (dma_req),
		.dma_addr     (dma_addr),
		.dma_wdata    (dma_wdata),
		.dma_busy     (dma_busy)
	);

	oam_ram i_ram (
		.clk     (clk),
		.cmd     (cmd),
		.rd_word (rd_word)
	);

endmodule

`default_nettype wire

// ==== bench/oam_checker.sv ====
`default_nettype none

module oam_checker (
	input wire                    clk,
	input wire                    arst_n,
	input wire                    dma_start,
	input wire                    dma_busy,
	input wire                    cpu_rd,
	input wire                    cpu_rvalid,
	input wire oam_pkg::oam_cmd_t cmd
);
	import oam_pkg::*;

	logic [7:0] busy_cnt;
	int         fail_cnt = 0;

	// Cycles of the running transfer. A restart counts from zero.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy_cnt <= '0;
		else if (dma_start || !dma_busy)
			busy_cnt <= '0;
		else
			busy_cnt <= busy_cnt + 8'd1;
	end

	a_dma_len: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(dma_busy) |-> busy_cnt == 8'(dma_len))
		else begin
			$error("dma_busy did not last one full transfer");
			fail_cnt++;
		end

	a_write_one_bank: assert property (@(posedge clk) disable iff (!arst_n)
		cmd.we |-> $onehot({cmd.cs_a, cmd.cs_b}))
		else begin
			$error("write enabled both banks or none");
			fail_cnt++;
		end

	a_read_both_banks: assert property (@(posedge clk) disable iff (!arst_n)
		(cmd.cs_a || cmd.cs_b) && !cmd.we |-> cmd.cs_a && cmd.cs_b)
		else begin
			$error("read enabled only one bank");
			fail_cnt++;
		end

	a_dma_owns: assert property (@(posedge clk) disable iff (!arst_n)
		dma_busy |-> cmd.owner == own_dma && cmd.we)
		else begin
			$error("DMA busy but does not own the memory");
			fail_cnt++;
		end

	a_rvalid_after_rd: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_rvalid == $past(cpu_rd))
		else begin
			$error("cpu_rvalid does not follow cpu_rd by one cycle");
			fail_cnt++;
		end

endmodule

bind ppu_oam oam_checker i_checker (
	.clk        (clk),
	.arst_n     (arst_n),
	.dma_start  (dma_start),
	.dma_busy   (dma_busy),
	.cpu_rd     (cpu_rd),
	.cpu_rvalid (cpu_rvalid),
	.cmd        (cmd)
);

`default_nettype wire

// ==== bench/oam_tb.sv ====
`default_nettype none

module oam_tb;
	import oam_pkg::*;

	localparam int max_cycles = 2000;   // The tests take about 950 cycles.

	logic               clk = 1'b0;
	logic               arst_n;
	logic               cpu_rd;
	logic               cpu_wr;
	oam_addr_u          cpu_addr;
	logic [7:0]         cpu_wdata;
	logic [7:0]         cpu_rdata;
	logic               cpu_rvalid;
	logic               dma_start;
	logic [7:0]         dma_page;
	logic [15:0]        dma_mem_addr;
	logic [7:0]         dma_mem_data;
	logic               dma_busy;
	logic               scan_start;
	logic               scan_active;
	scan_entry_t        scan_entry;
	logic               scan_done;
	logic               render_req;
	logic [5:0]         render_index;
	logic [7:0]         render_tile;
	logic [7:0]         render_attr;
	logic               render_valid;

	logic [7:0]  page_mem [65536];
	logic [7:0]  shadow [oam_bytes];   // Expected OAM contents.
	logic [15:0] lfsr = 16'd65;
	int          cycle_cnt = 0;
	int          test_errors = 0;
	int          total_errors = 0;
	int          failed_tests = 0;
	int          tests_run = 0;
	string       cur_test = "";

	ppu_oam i_dut (.*);

	assign dma_mem_data = page_mem[dma_mem_addr];   // Combinational page memory.

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("Run stopped, no end after %0d cycles", max_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	// Taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);   // One step per bit.
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic report_value(input string what, input int exp, input int act);
		$display("[ERROR] %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
		test_errors++;
	endtask

	task automatic report_fail(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("%s ok", cur_test);
		end else begin
			$display("%s failed with %0d errors", cur_test, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
		tests_run++;
	endtask

	task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_wr    <= 1'b1;
		cpu_addr  <= addr;
		cpu_wdata <= data;
		@(posedge clk);
		cpu_wr <= 1'b0;
	endtask

	task automatic read_byte(input logic [7:0] addr, output logic [7:0] data, output logic ok);
		@(posedge clk);
		cpu_rd   <= 1'b1;
		cpu_addr <= addr;
		@(posedge clk);
		cpu_rd <= 1'b0;
		@(negedge clk);   // Data is there for this one cycle.
		data = cpu_rdata;
		ok   = cpu_rvalid;
	endtask

	task automatic start_dma(input logic [7:0] page);
		@(posedge clk);
		dma_start <= 1'b1;
		dma_page  <= page;
		@(posedge clk);
		dma_start <= 1'b0;
	endtask

	task automatic wait_dma_idle();
		int n;
		n = 0;
		while (dma_busy && n < 2 * dma_len) begin
			@(negedge clk);
			n++;
		end
		if (dma_busy)
			report_fail("dma_busy never fell");
	endtask

	task automatic load_shadow(input logic [7:0] page);
		for (int i = 0; i < oam_bytes; i++)
			shadow[i] = page_mem[{page, 8'(i)}];
	endtask

	task automatic check_range(input int first, input int last);
		logic [7:0] d;
		logic       ok;
		for (int a = first; a <= last; a++) begin
			read_byte(8'(a), d, ok);
			if (!ok)
				report_fail($sformatf("no cpu_rvalid after read of byte %0d", a));
			else if (d !== shadow[a])
				report_value($sformatf("byte %0d", a), int'(shadow[a]), int'(d));
		end
	endtask

	task automatic check_render(input logic [5:0] idx, input logic [7:0] exp_tile,
			input logic [7:0] exp_attr);
		@(posedge clk);
		render_req   <= 1'b1;
		render_index <= idx;
		@(posedge clk);
		render_req <= 1'b0;
		@(negedge clk);
		if (!render_valid) begin
			report_fail($sformatf("no render_valid for entry %0d", idx));
		end else begin
			if (render_tile !== exp_tile)
				report_value($sformatf("tile %0d", idx), int'(exp_tile), int'(render_tile));
			if (render_attr !== exp_attr)
				report_value($sformatf("attr %0d", idx), int'(exp_attr), int'(render_attr));
		end
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------

	task automatic test_dma_copy();
		int len;
		begin_test("dma_copy");
		start_dma(8'h3A);
		len = 0;
		@(negedge clk);
		while (dma_busy && len < 2 * dma_len) begin
			len++;
			@(negedge clk);
		end
		if (len != dma_len)
			report_value("dma_busy cycles", dma_len, len);
		load_shadow(8'h3A);
		check_range(0, oam_bytes - 1);
		end_test();
	endtask

	task automatic test_cpu_access();
		int addrs[4] = '{20, 33, 0, 159};
		int lo;
		int hi;
		begin_test("cpu_access");
		foreach (addrs[i]) begin
			shadow[addrs[i]] = ~shadow[addrs[i]];
			write_byte(8'(addrs[i]), shadow[addrs[i]]);
			lo = (addrs[i] > 0) ? addrs[i] - 1 : 0;
			hi = (addrs[i] < oam_bytes - 1) ? addrs[i] + 1 : addrs[i];
			check_range(lo, hi);   // Row partner and neighbors stay put.
		end
		end_test();
	endtask

	task automatic test_cpu_blocked();
		logic [7:0] d;
		logic       ok;
		begin_test("cpu_blocked");
		start_dma(8'hC5);
		repeat (40) @(posedge clk);
		write_byte(8'd2, ~page_mem[16'hC502]);   // Both bytes are already copied.
		write_byte(8'd5, ~page_mem[16'hC505]);
		for (int a = 10; a < 13; a++) begin
			read_byte(8'(a), d, ok);
			if (!ok)
				report_fail("no cpu_rvalid for a read during DMA");
			else if (d !== open_bus)
				report_value($sformatf("blocked byte %0d", a), int'(open_bus), int'(d));
		end
		if (!dma_busy)
			report_fail("DMA ended before the blocked accesses were done");
		wait_dma_idle();
		load_shadow(8'hC5);
		check_range(0, 7);
		end_test();
	endtask

	task automatic test_line_scan();
		int got;
		int waited;
		begin_test("line_scan");
		@(posedge clk);
		scan_start <= 1'b1;
		@(posedge clk);
		scan_start <= 1'b0;
		got    = 0;
		waited = 0;
		while (got < oam_entries && waited < 3 * oam_entries) begin
			@(negedge clk);
			waited++;
			if (waited == 1 && !scan_active)
				report_fail("scan_active did not rise after scan_start");
			if (scan_entry.valid) begin
				if (scan_entry.index !== 6'(got))
					report_value("entry index", got, int'(scan_entry.index));
				if (scan_entry.y !== shadow[4 * got])
					report_value($sformatf("entry %0d y", got), int'(shadow[4 * got]),
						int'(scan_entry.y));
				if (scan_entry.x !== shadow[4 * got + 1])
					report_value($sformatf("entry %0d x", got), int'(shadow[4 * got + 1]),
						int'(scan_entry.x));
				if (scan_done != (got == oam_entries - 1))
					report_fail($sformatf("scan_done wrong at entry %0d", got));
				// The read of the next entry is still in flight.
				if (scan_active !== (got < oam_entries - 1))
					report_fail($sformatf("scan_active wrong at entry %0d", got));
				got++;
			end
		end
		if (got != oam_entries)
			report_value("scan entries", oam_entries, got);
		@(negedge clk);
		if (scan_active || scan_entry.valid)
			report_fail("scan still running after the last entry");
		end_test();
	endtask

	task automatic test_render();
		begin_test("render");
		check_render(6'd7, shadow[30], shadow[31]);
		check_render(6'd39, shadow[158], shadow[159]);
		start_dma(8'h12);
		check_render(6'd12, open_bus, open_bus);   // Loses to the DMA.
		wait_dma_idle();
		load_shadow(8'h12);
		check_render(6'd12, shadow[50], shadow[51]);
		end_test();
	endtask

	initial begin
		arst_n       <= 1'b0;
		cpu_rd       <= 1'b0;
		cpu_wr       <= 1'b0;
		cpu_addr     <= '0;
		cpu_wdata    <= '0;
		dma_start    <= 1'b0;
		dma_page     <= '0;
		scan_start   <= 1'b0;
		render_req   <= 1'b0;
		render_index <= '0;
		for (int a = 0; a < 65536; a++)
			rand_byte(page_mem[a]);
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		test_dma_copy();   // Fills OAM for the tests after it.
		test_cpu_access();
		test_cpu_blocked();
		test_line_scan();
		test_render();

		if (i_dut.i_checker.fail_cnt != 0) begin
			$display("Bound checker saw %0d assertion failures", i_dut.i_checker.fail_cnt);
			total_errors += i_dut.i_checker.fail_cnt;
		end
		$display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, total_errors);
		if (total_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/oam_pkg.sv
source/oam_arbiter.sv
source/oam_scan_counter.sv
source/oam_dma_engine.sv
source/oam_ram.sv
source/ppu_oam.sv
bench/oam_checker.sv
bench/oam_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= oam_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
